/* rtl/rv32i_pkg.sv */
package rv32i_pkg;

  typedef enum logic [6:0] {
    op_r      = 7'b0110011,
    op_i      = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu
  } alu_op_t;

  typedef enum logic [1:0] {imm_i, imm_s, imm_b} imm_fmt_t;

  typedef enum logic {wb_alu, wb_mem} wb_sel_t;   // register write-back source

  typedef enum logic {addr_pc, addr_alu} addr_sel_t;   // fetch or data address

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_memory,
    st_writeback
  } ctrl_state_t;

  // lsb of each instruction field
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;

endpackage

/* rtl/core_ctrl_if.sv */
`timescale 1ns/1ps

interface core_ctrl_if import rv32i_pkg::*; ();
  logic        ir_load;
  logic        operand_load;
  logic        alu_result_load;
  logic        load_data_load;
  logic        pc_load;
  logic        branch_sel;   // pc takes the branch target
  alu_op_t     alu_op;
  logic        src_b_imm;
  imm_fmt_t    imm_fmt;
  logic        reg_write;
  wb_sel_t     wb_sel;
  addr_sel_t   addr_sel;
  logic        mem_write;
  logic [31:0] instr;        // instruction register
  logic        alu_zero;

  modport ctrl (output ir_load, operand_load, alu_result_load, load_data_load, pc_load,
                branch_sel, alu_op, src_b_imm, imm_fmt, reg_write, wb_sel, addr_sel,
                mem_write, input instr, alu_zero);
  modport dp (input ir_load, operand_load, alu_result_load, load_data_load, pc_load,
              branch_sel, alu_op, src_b_imm, imm_fmt, reg_write, wb_sel, addr_sel,
              mem_write, output instr, alu_zero);
endinterface

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic        clk,
  input  logic [4:0]  rd_addr0,
  input  logic [4:0]  rd_addr1,
  input  logic        wr_ena,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data,
  output logic [31:0] rd_data0,
  output logic [31:0] rd_data1
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (wr_ena && wr_addr != 5'd0) begin   // x0 is never written
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data0 = (rd_addr0 == 5'd0) ? 32'd0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == 5'd0) ? 32'd0 : regs[rd_addr1];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu
  import rv32i_pkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_t     op,
  output logic [31:0] result,
  output logic        zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];   // shifts only use the low five bits

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_sll:  result = a << shamt;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $unsigned($signed(a) >>> shamt);
      alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
      alu_sltu: result = {31'd0, a < b};
      default:  result = 32'd0;
    endcase
  end

  assign zero = (result == 32'd0);

endmodule

/* rtl/immediate_extender.sv */
`timescale 1ns/1ps

module immediate_extender
  import rv32i_pkg::*;
(
  input  logic [31:0] instr,
  input  imm_fmt_t    fmt,
  output logic [31:0] imm
);

  always_comb begin
    case (fmt)
      imm_i: imm = {{20{instr[31]}}, instr[rs2_lsb +: 12]};
      imm_s: imm = {{20{instr[31]}}, instr[funct7_lsb +: 7], instr[rd_lsb +: 5]};
      // branch offsets are always even
      imm_b: imm = {{20{instr[31]}}, instr[rd_lsb], instr[funct7_lsb +: 6],
                    instr[rd_lsb + 1 +: 4], 1'b0};
      default: imm = 32'd0;
    endcase
  end

endmodule

/* rtl/rv32i_datapath.sv */
`timescale 1ns/1ps

module rv32i_datapath
  import rv32i_pkg::*;
#(
  parameter logic [31:0] pc_start_address = 32'd0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        ena,
  input  logic [31:0] mem_rd_data,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wr_data,
  output logic        mem_wr_ena,
  output logic [31:0] pc,
  core_ctrl_if.dp     dp
);

  logic [31:0] ir;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] store_data;     // rs2 kept for sw
  logic [31:0] branch_target;
  logic [31:0] alu_result;
  logic [31:0] load_data;

  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm;
  logic [31:0] src_b;
  logic [31:0] alu_out;
  logic [31:0] wb_data;
  logic [31:0] pc_next;

  register_file i_register_file (
    .clk      (clk),
    .rd_addr0 (ir[rs1_lsb +: 5]),
    .rd_addr1 (ir[rs2_lsb +: 5]),
    .wr_ena   (dp.reg_write),
    .wr_addr  (ir[rd_lsb +: 5]),
    .wr_data  (wb_data),
    .rd_data0 (rs1_data),
    .rd_data1 (rs2_data)
  );

  immediate_extender i_immediate_extender (
    .instr (ir),
    .fmt   (dp.imm_fmt),
    .imm   (imm)
  );

  alu i_alu (
    .a      (operand_a),
    .b      (operand_b),
    .op     (dp.alu_op),
    .result (alu_out),
    .zero   (dp.alu_zero)
  );

  assign src_b   = dp.src_b_imm ? imm : rs2_data;
  assign wb_data = (dp.wb_sel == wb_mem) ? load_data : alu_result;
  assign pc_next = dp.branch_sel ? branch_target : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= pc_start_address;
    end else if (dp.pc_load) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (dp.ir_load) ir <= mem_rd_data;
    if (dp.operand_load) begin
      operand_a     <= rs1_data;
      operand_b     <= src_b;
      store_data    <= rs2_data;
      branch_target <= pc + imm;   // only meaningful with imm_b selected
    end
    if (dp.alu_result_load) alu_result <= alu_out;
    if (dp.load_data_load) load_data <= mem_rd_data;
  end

  assign dp.instr    = ir;
  assign mem_addr    = (dp.addr_sel == addr_alu) ? alu_result : pc;
  assign mem_wr_data = store_data;
  assign mem_wr_ena  = dp.mem_write & ena;   // strobe is already gated, kept low on hold

endmodule

/* rtl/rv32i_controller.sv */
`timescale 1ns/1ps

module rv32i_controller
  import rv32i_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ena,
  core_ctrl_if.ctrl ctrl
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  opcode_t     opcode;
  logic [2:0]  funct3;
  logic        funct7_alt;     // instr bit 30, selects sub and sra
  alu_op_t     alu_op_dec;
  logic        branch_taken;

  assign opcode     = opcode_t'(ctrl.instr[6:0]);
  assign funct3     = ctrl.instr[funct3_lsb +: 3];
  assign funct7_alt = ctrl.instr[funct7_lsb + 5];

  // alu operation for the execute cycle
  always_comb begin
    alu_op_dec = alu_add;
    case (opcode)
      op_r, op_i: begin
        case (funct3)
          3'b000: alu_op_dec = (opcode == op_r && funct7_alt) ? alu_sub : alu_add;
          3'b001: alu_op_dec = alu_sll;
          3'b010: alu_op_dec = alu_slt;
          3'b011: alu_op_dec = alu_sltu;
          3'b100: alu_op_dec = alu_xor;
          3'b101: alu_op_dec = funct7_alt ? alu_sra : alu_srl;   // i-type shifts too
          3'b110: alu_op_dec = alu_or;
          default: alu_op_dec = alu_and;
        endcase
      end
      op_branch: alu_op_dec = funct3[2] ? alu_slt : alu_sub;   // blt/bge compare with slt
      default:   alu_op_dec = alu_add;                         // address add for lw/sw
    endcase
  end

  // slt result of 1 clears the zero flag, so blt is taken on !zero
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = ctrl.alu_zero;    // beq
      3'b001:  branch_taken = !ctrl.alu_zero;   // bne
      3'b100:  branch_taken = !ctrl.alu_zero;   // blt
      3'b101:  branch_taken = ctrl.alu_zero;    // bge
      default: branch_taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
    end else if (ena) begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next           = state;
    ctrl.ir_load         = 1'b0;
    ctrl.operand_load    = 1'b0;
    ctrl.alu_result_load = 1'b0;
    ctrl.load_data_load  = 1'b0;
    ctrl.pc_load         = 1'b0;
    ctrl.branch_sel      = 1'b0;
    ctrl.alu_op          = alu_op_dec;
    ctrl.src_b_imm       = 1'b0;
    ctrl.imm_fmt         = imm_i;
    ctrl.reg_write       = 1'b0;
    ctrl.wb_sel          = (opcode == op_load) ? wb_mem : wb_alu;
    ctrl.addr_sel        = addr_pc;
    ctrl.mem_write       = 1'b0;
    case (state)
      st_fetch: begin
        ctrl.ir_load = 1'b1;
        state_next   = st_decode;
      end
      st_decode: begin
        ctrl.operand_load = 1'b1;
        state_next        = st_execute;
        case (opcode)
          op_r: ctrl.src_b_imm = 1'b0;
          op_i, op_load: ctrl.src_b_imm = 1'b1;
          op_store: begin
            ctrl.src_b_imm = 1'b1;
            ctrl.imm_fmt   = imm_s;
          end
          op_branch: ctrl.imm_fmt = imm_b;   // operand b stays rs2, imm feeds the target
          default: begin
            ctrl.operand_load = 1'b0;   // unknown opcode skips to next word
            ctrl.pc_load      = 1'b1;
            state_next        = st_fetch;
          end
        endcase
      end
      st_execute: begin
        ctrl.alu_result_load = 1'b1;
        if (opcode == op_branch) begin
          ctrl.pc_load    = 1'b1;
          ctrl.branch_sel = branch_taken;
          state_next      = st_fetch;
        end else if (opcode == op_load || opcode == op_store) begin
          state_next = st_memory;
        end else begin
          state_next = st_writeback;
        end
      end
      st_memory: begin
        ctrl.addr_sel = addr_alu;
        if (opcode == op_store) begin
          ctrl.mem_write = 1'b1;
          ctrl.pc_load   = 1'b1;
          state_next     = st_fetch;
        end else begin
          ctrl.load_data_load = 1'b1;
          state_next          = st_writeback;
        end
      end
      st_writeback: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_load   = 1'b1;
        state_next     = st_fetch;
      end
      default: state_next = st_fetch;
    endcase
    if (!ena) begin   // hold everything while disabled
      ctrl.ir_load         = 1'b0;
      ctrl.operand_load    = 1'b0;
      ctrl.alu_result_load = 1'b0;
      ctrl.load_data_load  = 1'b0;
      ctrl.pc_load         = 1'b0;
      ctrl.reg_write       = 1'b0;
      ctrl.mem_write       = 1'b0;
    end
  end

endmodule

/* rtl/rv32i_multicycle_core.sv */
`timescale 1ns/1ps

module rv32i_multicycle_core #(
  parameter logic [31:0] pc_start_address = 32'd0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        ena,
  input  logic [31:0] mem_rd_data,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wr_data,
  output logic        mem_wr_ena,
  output logic [31:0] pc
);

  core_ctrl_if ctrl_bus ();

  rv32i_controller i_rv32i_controller (
    .clk  (clk),
    .rst  (rst),
    .ena  (ena),
    .ctrl (ctrl_bus)
  );

  rv32i_datapath #(
    .pc_start_address (pc_start_address)
  ) i_rv32i_datapath (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .mem_rd_data (mem_rd_data),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_ena  (mem_wr_ena),
    .pc          (pc),
    .dp          (ctrl_bus)
  );

endmodule

/* test/rv32i_core_checker.sv */
`timescale 1ns/1ps

module rv32i_core_checker (
  input logic        clk,
  input logic        rst,
  input logic        ena,
  input logic        mem_wr_ena,
  input logic [31:0] pc
);

  int failures = 0;   // read by the testbench at the end of the run

  single_write: assert property (@(posedge clk) disable iff (rst) mem_wr_ena |=> !mem_wr_ena)
    else begin
      failures++;
      $error("mem_wr_ena stayed high for two cycles");
    end

  quiet_write: assert property (@(posedge clk) (rst || !ena) |-> !mem_wr_ena)
    else begin
      failures++;
      $error("mem_wr_ena high during reset or while disabled");
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      failures++;
      $error("pc is not word aligned");
    end

  // a disabled cycle leaves the pc where it was
  pc_hold: assert property (@(posedge clk) disable iff (rst) !ena |=> $stable(pc))
    else begin
      failures++;
      $error("pc moved while ena was low");
    end

endmodule

bind rv32i_multicycle_core rv32i_core_checker i_rv32i_core_checker (
  .clk        (clk),
  .rst        (rst),
  .ena        (ena),
  .mem_wr_ena (mem_wr_ena),
  .pc         (pc)
);

/* test/rv32i_core_tb.sv */
`timescale 1ns/1ps

module rv32i_core_tb
  import rv32i_pkg::*;
();

  // instructions per test including the final self-branch
  // the hold test runs its program twice
  localparam int total_instrs = 1 + 43 + 10 + 44 + 2 * 10 + 7;
  localparam int cycle_limit  = 5 * total_instrs + 200;

  // funct3, instr bit 30 and ALU operation of test operation k
  localparam logic [29:0] f3_list  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
  localparam logic [9:0]  alt_list = 10'b0010000010;
  localparam logic [39:0] op_list  = {alu_and, alu_or, alu_sra, alu_srl, alu_xor, alu_sltu,
                                      alu_slt, alu_sll, alu_sub, alu_add};

  logic        clk = 1'b0;
  logic        rst;
  logic        ena;
  logic [31:0] mem_rd_data;
  logic [31:0] mem_addr;
  logic [31:0] mem_wr_data;
  logic        mem_wr_ena;
  logic [31:0] pc;

  logic [31:0] mem [256];
  logic [31:0] prog [$];
  logic [31:0] done_pc;
  logic [31:0] seed = 32'hcd40_f35f;
  int          errors = 0;
  int          cycles = 0;

  rv32i_multicycle_core #(
    .pc_start_address (32'd0)
  ) i_rv32i_multicycle_core (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .mem_rd_data (mem_rd_data),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_ena  (mem_wr_ena),
    .pc          (pc)
  );

  always #10 clk = ~clk;

  assign mem_rd_data = mem[mem_addr[9:2]];   // combinational read

  always @(posedge clk) begin
    if (mem_wr_ena) mem[mem_addr[9:2]] <= mem_wr_data;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the core never reached its final branch", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] fill_word(int i);
    return 32'hf00d_0000 + i;
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_r};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_lw(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
    return enc_i(imm, rs1, 3'b010, rd, op_load);
  endfunction

  function automatic logic [31:0] enc_sw(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  // RV32I result rules with the shift amount in the low five bits of b
  function automatic logic [31:0] ref_alu(alu_op_t op, logic [31:0] a, logic [31:0] b);
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or:  return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: return $signed(a) >>> b[4:0];
      alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return (a < b) ? 32'd1 : 32'd0;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    assert (actual === expected) else begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_word(int i, logic [31:0] expected);
    check_value($sformatf("mem[%0d]", i), mem[i], expected);
  endtask

  // holds reset, refills memory and places prog at address 0
  task automatic start_program();
    int i;
    @(negedge clk);
    rst = 1'b1;
    for (i = 0; i < 256; i++) mem[i] <= fill_word(i);
    for (i = 0; i < prog.size(); i++) mem[i] <= prog[i];
    mem[prog.size()] <= enc_b(13'd0, 5'd0, 5'd0, 3'b000);   // self-branch ends the program
    done_pc = 4 * prog.size();
  endtask

  task automatic release_reset();
    repeat (3) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic run_to_end();
    while (pc !== done_pc) @(negedge clk);
  endtask

  task automatic test_reset();
    prog.delete();
    start_program();
    release_reset();
    check_value("pc", pc, 32'd0);
    check_value("mem_wr_ena", {31'd0, mem_wr_ena}, 32'd0);
    check_value("mem_addr", mem_addr, 32'd0);
    run_to_end();
  endtask

  task automatic test_alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [31:0] expect_q [$];
    int k;
    a = next_rand();
    b = next_rand();
    prog.delete();
    prog.push_back(enc_lw(12'h200, 5'd0, 5'd1));
    prog.push_back(enc_lw(12'h204, 5'd0, 5'd2));
    for (k = 0; k < 10; k++) begin   // R-type x3 = x1 op x2
      f3 = f3_list[3 * k +: 3];
      prog.push_back(enc_r({1'b0, alt_list[k], 5'd0}, 5'd2, 5'd1, f3, 5'd3));
      prog.push_back(enc_sw(12'h300 + 4 * expect_q.size(), 5'd3, 5'd0));
      expect_q.push_back(ref_alu(alu_op_t'(op_list[4 * k +: 4]), a, b));
    end
    for (k = 0; k < 10; k++) begin   // I-type skips k = 1 as there is no subi
      if (k == 1) continue;
      f3 = f3_list[3 * k +: 3];
      r = next_rand();
      imm = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt_list[k], 5'd0, r[4:0]} : r[11:0];
      prog.push_back(enc_i(imm, 5'd1, f3, 5'd4, op_i));
      prog.push_back(enc_sw(12'h300 + 4 * expect_q.size(), 5'd4, 5'd0));
      expect_q.push_back(ref_alu(alu_op_t'(op_list[4 * k +: 4]), a, {{20{imm[11]}}, imm}));
    end
    prog.push_back(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0));   // write to x0 is dropped
    prog.push_back(enc_sw(12'h300 + 4 * expect_q.size(), 5'd0, 5'd0));
    expect_q.push_back(32'd0);
    start_program();
    mem[128] <= a;
    mem[129] <= b;
    release_reset();
    run_to_end();
    for (k = 0; k < expect_q.size(); k++) check_word(192 + k, expect_q[k]);
  endtask

  // copies two words through registers with positive and negative offsets
  task automatic run_copy(logic [31:0] v0, logic [31:0] v1, int hold_at);
    logic [31:0] pc_held;
    logic [31:0] held [256];
    int i;
    prog.delete();
    prog.push_back(enc_i(12'h240, 5'd0, 3'd0, 5'd5, op_i));   // base 0x240
    prog.push_back(enc_lw(-12'sd64, 5'd5, 5'd6));
    prog.push_back(enc_lw(12'h010, 5'd5, 5'd7));
    prog.push_back(enc_sw(12'h020, 5'd6, 5'd5));
    prog.push_back(enc_sw(-12'sd32, 5'd7, 5'd5));
    prog.push_back(enc_lw(12'h020, 5'd5, 5'd8));
    prog.push_back(enc_lw(-12'sd32, 5'd5, 5'd9));
    prog.push_back(enc_sw(12'h080, 5'd8, 5'd5));
    prog.push_back(enc_sw(12'h084, 5'd9, 5'd5));
    start_program();
    mem[128] <= v0;
    mem[148] <= v1;
    release_reset();
    if (hold_at > 0) begin
      repeat (hold_at) @(negedge clk);
      ena = 1'b0;
      pc_held = pc;
      for (i = 0; i < 256; i++) held[i] = mem[i];
      repeat (20) begin
        @(negedge clk);
        check_value("pc", pc, pc_held);
      end
      for (i = 0; i < 256; i++) check_word(i, held[i]);
      ena = 1'b1;
    end
    run_to_end();
  endtask

  task automatic test_load_store();
    logic [31:0] v0;
    logic [31:0] v1;
    v0 = next_rand();
    v1 = next_rand();
    run_copy(v0, v1, 0);
    check_word(152, v0);
    check_word(136, v1);
    check_word(176, v0);
    check_word(177, v1);
  endtask

  task automatic test_branches();
    // register pair of case c out of x1 = -5, x2 = 3 and x3 = 3
    // even cases take the branch
    localparam logic [15:0] rs1_list = 16'b01_10_10_01_10_01_01_10;
    localparam logic [15:0] rs2_list = 16'b10_01_01_10_11_10_10_11;
    logic [2:0] f3;
    logic       taken;
    int c;
    prog.delete();
    prog.push_back(enc_i(12'hffb, 5'd0, 3'd0, 5'd1, op_i));
    prog.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd2, op_i));
    prog.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd3, op_i));
    for (c = 0; c < 8; c++) begin
      f3 = (c / 2 == 0) ? 3'b000 : (c / 2 == 1) ? 3'b001 : (c / 2 == 2) ? 3'b100 : 3'b101;
      prog.push_back(enc_i(12'h100 + c, 5'd0, 3'd0, 5'd10, op_i));   // marker
      prog.push_back(enc_b(13'd12, {3'd0, rs2_list[2 * c +: 2]}, {3'd0, rs1_list[2 * c +: 2]}, f3));
      prog.push_back(enc_sw(12'h300 + 8 * c, 5'd10, 5'd0));       // fall-through path
      prog.push_back(enc_b(13'd8, 5'd0, 5'd0, 3'b000));
      prog.push_back(enc_sw(12'h304 + 8 * c, 5'd10, 5'd0));       // taken path
    end
    start_program();
    release_reset();
    run_to_end();
    for (c = 0; c < 8; c++) begin
      taken = (c % 2 == 0);
      check_word(192 + 2 * c + taken, 32'h100 + c);
      check_word(192 + 2 * c + !taken, fill_word(192 + 2 * c + !taken));
    end
  endtask

  task automatic test_enable_hold();
    logic [31:0] golden [256];
    logic [31:0] v0;
    logic [31:0] v1;
    int i;
    v0 = next_rand();
    v1 = next_rand();
    run_copy(v0, v1, 0);
    for (i = 0; i < 256; i++) golden[i] = mem[i];
    run_copy(v0, v1, 17);   // stall lands inside the first store
    for (i = 0; i < 256; i++) check_word(i, golden[i]);
  endtask

  task automatic test_unknown_opcode();
    int i;
    prog.delete();
    prog.push_back(enc_i(12'h055, 5'd0, 3'd0, 5'd1, op_i));
    prog.push_back({20'hfffff, 5'd1, 7'b0110111});   // lui x1 that must not execute
    prog.push_back(32'h0000_0073);                   // ecall
    prog.push_back(enc_sw(12'h300, 5'd1, 5'd0));
    prog.push_back(enc_i(12'h066, 5'd0, 3'd0, 5'd2, op_i));
    prog.push_back(enc_sw(12'h304, 5'd2, 5'd0));
    start_program();
    release_reset();
    run_to_end();
    for (i = 128; i < 256; i++) begin
      check_word(i, (i == 192) ? 32'h55 : (i == 193) ? 32'h66 : fill_word(i));
    end
  endtask

  initial begin
    int assert_fails;
    rst = 1'b1;
    ena = 1'b1;
    test_reset();
    test_alu_ops();
    test_load_store();
    test_branches();
    test_enable_hold();
    test_unknown_opcode();
    assert_fails = i_rv32i_multicycle_core.i_rv32i_core_checker.failures;
    $display("failed checks: %0d, failed assertions: %0d", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/rv32i_pkg.sv
rtl/core_ctrl_if.sv
rtl/register_file.sv
rtl/alu.sv
rtl/immediate_extender.sv
rtl/rv32i_datapath.sv
rtl/rv32i_controller.sv
rtl/rv32i_multicycle_core.sv
test/rv32i_core_checker.sv
test/rv32i_core_tb.sv
